// File: dv/pipe_trace_tb.sv
////////////////////////////////////////////////////////////////////////////
// Directed testbench for the pipeline trace unit, with a stage model
// that predicts every retire record, hazard event and counter value
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_trace_tb;

    // Stage indices of the model
    localparam int FE = 0;
    localparam int DE = 1;
    localparam int EX = 2;
    localparam int ME = 3;
    localparam int WB = 4;

    // Cycles spent by each test and summed for the timeout
    localparam int RESET_CYCLES  = 5;
    localparam int FREE_CYCLES   = 24;
    localparam int STALL_CYCLES  = 24;
    localparam int FLUSH_CYCLES  = 13;
    localparam int BOTH_CYCLES   = 13;
    localparam int RANDOM_CYCLES = 210;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + FREE_CYCLES + STALL_CYCLES
                                  + FLUSH_CYCLES + BOTH_CYCLES + RANDOM_CYCLES + 50;

    logic                                clk;
    logic                                rst;
    logic                                stall;
    logic                                flush;
    trace_pkg::stage_probe_t             probe;
    logic                                retire_valid;
    trace_pkg::retire_record_t           retire;
    logic [trace_pkg::CNT_W-1:0]         retire_count;
    logic                                hazard_valid;
    trace_pkg::hazard_event_t            hazard;
    logic [trace_pkg::CNT_W-1:0]         stall_count;
    logic [trace_pkg::CNT_W-1:0]         flush_count;

    // Model state
    logic                                m_valid [5];
    logic [trace_pkg::ID_W-1:0]          m_id [5];
    logic [trace_pkg::CYC_W-1:0]         m_cycle;
    trace_pkg::trace_record_t            m_rec [256];
    logic [trace_pkg::CNT_W-1:0]         m_retire_cnt;
    logic [trace_pkg::CNT_W-1:0]         m_stall_cnt;
    logic [trace_pkg::CNT_W-1:0]         m_flush_cnt;
    logic                                exp_retire_valid;
    trace_pkg::retire_record_t           exp_retire;
    logic                                exp_hazard_valid;
    trace_pkg::hazard_event_t            exp_hazard;
    logic                                check_on;

    // Observed strobes and discarded ids that each test clears first
    trace_pkg::retire_record_t           retired_q [$];
    trace_pkg::hazard_event_t            hazard_q [$];
    logic [trace_pkg::ID_W-1:0]          flushed_ids [$];

    logic [31:0]                         rng;
    int                                  cycle_count;
    int                                  fail_count;

    pipe_trace_top DUT (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .probe        (probe),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_count (retire_count),
        .hazard_valid (hazard_valid),
        .hazard       (hazard),
        .stall_count  (stall_count),
        .flush_count  (flush_count)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string msg);
        fail_count++;
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [319:0] got,
                             input logic [319:0] want);
        assert (got === want) else
            report_failure($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                     $time, name, got, want));
    endtask

    task automatic require(input logic cond, input string what);
        assert (cond === 1'b1) else
            report_failure($sformatf("at %0t: %s", $time, what));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw_word(output logic [31:0] r);
        rng = xorshift32(rng);
        r = rng;
    endtask

    // One clock of stimulus with fresh probe values
    task automatic step(input logic s, input logic f);
        trace_pkg::stage_probe_t p;
        draw_word(p.fetch_pc);
        draw_word(p.fetch_instr);
        draw_word(p.ex_result);
        draw_word(p.mem_addr);
        draw_word(p.wb_data);
        @(posedge clk);
        stall <= s;
        flush <= f;
        probe <= p;
    endtask

    task automatic settle();
        @(negedge clk);
    endtask

    task automatic clear_logs();
        retired_q.delete();
        hazard_q.delete();
        flushed_ids.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stage model
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_model();
        for (int i = 0; i < 5; i++) begin
            m_valid[i] = 1'b0;
            m_id[i] = '0;
        end
        m_valid[FE] = 1'b1;
        m_cycle = '0;
        m_retire_cnt = '0;
        m_stall_cnt = '0;
        m_flush_cnt = '0;
        exp_retire_valid = 1'b0;
        exp_hazard_valid = 1'b0;
    endtask

    task automatic advance_model();
        // Every valid stage records this cycle and its probe field
        if (m_valid[FE]) begin
            m_rec[m_id[FE]].id = m_id[FE];
            m_rec[m_id[FE]].pc = probe.fetch_pc;
            m_rec[m_id[FE]].instr = probe.fetch_instr;
            m_rec[m_id[FE]].fetch_cyc = m_cycle;
        end
        if (m_valid[DE]) begin
            m_rec[m_id[DE]].decode_cyc = m_cycle;
        end
        if (m_valid[EX]) begin
            m_rec[m_id[EX]].execute_cyc = m_cycle;
            m_rec[m_id[EX]].ex_result = probe.ex_result;
        end
        if (m_valid[ME]) begin
            m_rec[m_id[ME]].memory_cyc = m_cycle;
            m_rec[m_id[ME]].mem_addr = probe.mem_addr;
        end
        if (m_valid[WB]) begin
            m_rec[m_id[WB]].wb_cyc = m_cycle;
            m_rec[m_id[WB]].wb_data = probe.wb_data;
        end

        // Retire shows up one cycle after the wb cycle
        exp_retire_valid = m_valid[WB];
        if (m_valid[WB]) begin
            exp_retire.rec = m_rec[m_id[WB]];
            exp_retire.latency = m_cycle + 1'b1 - m_rec[m_id[WB]].fetch_cyc;
            m_retire_cnt = m_retire_cnt + 1'b1;
        end

        exp_hazard_valid = stall | flush;
        if (stall || flush) begin
            exp_hazard.cause = stall ? trace_pkg::CAUSE_STALL : trace_pkg::CAUSE_FLUSH;
            exp_hazard.cycle = m_cycle;
        end
        if (stall && m_stall_cnt != '1) begin
            m_stall_cnt = m_stall_cnt + 1'b1;
        end
        if (flush && m_flush_cnt != '1) begin
            m_flush_cnt = m_flush_cnt + 1'b1;
        end

        // Move back to front so each stage reads the old state
        m_valid[WB] = m_valid[ME];
        m_id[WB] = m_id[ME];
        m_valid[ME] = m_valid[EX];
        m_id[ME] = m_id[EX];
        if (stall) begin
            m_valid[EX] = 1'b0;
        end else begin
            m_valid[EX] = m_valid[DE];
            m_id[EX] = m_id[DE];
            if (flush) begin
                flushed_ids.push_back(m_id[FE]);
                m_valid[DE] = 1'b0;
            end else begin
                m_valid[DE] = m_valid[FE];
                m_id[DE] = m_id[FE];
            end
            m_id[FE] = m_id[FE] + 8'd1;
        end
        m_cycle = m_cycle + 1'b1;
    endtask

    // Compare the registered outputs, then step the model
    always @(posedge clk) begin
        if (check_on) begin
            check_val("retire_valid", retire_valid, exp_retire_valid);
            if (exp_retire_valid) begin
                check_val("retire", retire, exp_retire);
                retired_q.push_back(retire);
            end
            check_val("retire_count", retire_count, m_retire_cnt);
            check_val("hazard_valid", hazard_valid, exp_hazard_valid);
            if (exp_hazard_valid) begin
                check_val("hazard", hazard, exp_hazard);
                hazard_q.push_back(hazard);
            end
            check_val("stall_count", stall_count, m_stall_cnt);
            check_val("flush_count", flush_count, m_flush_cnt);
        end
        if (!rst) begin
            reset_model();
            check_on = 1'b1;
        end else begin
            advance_model();
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure("timeout: the tests did not finish within the cycle limit");
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic free_run();
        trace_pkg::retire_record_t r;
        clear_logs();
        repeat (FREE_CYCLES) step(1'b0, 1'b0);
        settle();
        require(retired_q.size() >= 15, "too few retires in the free run");
        check_val("retire.rec.id", retired_q[0].rec.id, 8'd0);
        for (int i = 0; i < retired_q.size(); i++) begin
            r = retired_q[i];
            check_val("retire.latency", r.latency, 16'd5);
            require(r.rec.decode_cyc == r.rec.fetch_cyc + 1'b1, "decode stamp gap");
            require(r.rec.execute_cyc == r.rec.decode_cyc + 1'b1, "execute stamp gap");
            require(r.rec.memory_cyc == r.rec.execute_cyc + 1'b1, "memory stamp gap");
            require(r.rec.wb_cyc == r.rec.memory_cyc + 1'b1, "wb stamp gap");
            if (i > 0) begin
                require(r.rec.id == retired_q[i-1].rec.id + 8'd1, "ids retired out of order");
            end
        end
    endtask

    task automatic stall_sequence();
        logic [trace_pkg::CNT_W-1:0] stalls_before;
        int lat6;
        int lat8;
        stalls_before = m_stall_cnt;
        lat6 = 0;
        lat8 = 0;
        clear_logs();
        repeat (6) step(1'b0, 1'b0);
        step(1'b1, 1'b0);
        repeat (6) step(1'b0, 1'b0);
        repeat (3) step(1'b1, 1'b0);
        repeat (8) step(1'b0, 1'b0);
        settle();
        // Only the instruction held in decode loses the stall cycles
        foreach (retired_q[i]) begin
            if (retired_q[i].latency == 16'd6) begin
                lat6++;
            end else if (retired_q[i].latency == 16'd8) begin
                lat8++;
            end else begin
                require(retired_q[i].latency == 16'd5, "unexpected latency around a stall");
            end
        end
        require(lat6 == 1, "one-cycle stall did not add one cycle once");
        require(lat8 == 1, "three-cycle stall did not add three cycles once");
        check_val("stall_count", stall_count, stalls_before + 16'd4);
        require(hazard_q.size() == 4, "wrong number of stall events");
        foreach (hazard_q[i]) begin
            require(hazard_q[i].cause == trace_pkg::CAUSE_STALL, "stall event cause is flush");
        end
    endtask

    task automatic flush_sequence();
        logic [trace_pkg::CNT_W-1:0] flushes_before;
        logic [trace_pkg::ID_W-1:0]  gone;
        logic                        skip_seen;
        flushes_before = m_flush_cnt;
        skip_seen = 1'b0;
        clear_logs();
        repeat (4) step(1'b0, 1'b0);
        step(1'b0, 1'b1);
        repeat (8) step(1'b0, 1'b0);
        settle();
        require(flushed_ids.size() == 1, "flush did not discard exactly one id");
        gone = flushed_ids[0];
        foreach (retired_q[i]) begin
            require(retired_q[i].rec.id != gone, "a flushed id was retired");
            if (i > 0 && retired_q[i].rec.id == gone + 8'd1
                    && retired_q[i-1].rec.id == gone - 8'd1) begin
                skip_seen = 1'b1;
            end
        end
        require(skip_seen, "retire sequence does not skip the flushed id");
        check_val("flush_count", flush_count, flushes_before + 16'd1);
        require(hazard_q.size() == 1, "wrong number of flush events");
        require(hazard_q[0].cause == trace_pkg::CAUSE_FLUSH, "flush event has stall cause");
    endtask

    task automatic stall_with_flush();
        logic [trace_pkg::CNT_W-1:0] stalls_before;
        logic [trace_pkg::CNT_W-1:0] flushes_before;
        stalls_before = m_stall_cnt;
        flushes_before = m_flush_cnt;
        clear_logs();
        repeat (4) step(1'b0, 1'b0);
        step(1'b1, 1'b1);
        repeat (8) step(1'b0, 1'b0);
        settle();
        require(retired_q.size() >= 8, "too few retires around the stall and flush");
        for (int i = 1; i < retired_q.size(); i++) begin
            require(retired_q[i].rec.id == retired_q[i-1].rec.id + 8'd1,
                    "ids skipped although stall won over flush");
        end
        check_val("stall_count", stall_count, stalls_before + 16'd1);
        check_val("flush_count", flush_count, flushes_before + 16'd1);
        require(hazard_q.size() == 1, "wrong number of hazard events");
        require(hazard_q[0].cause == trace_pkg::CAUSE_STALL, "cause is not stall");
    endtask

    task automatic random_mix();
        logic [31:0] r;
        logic        s;
        logic        f;
        int          hazards;
        hazards = 0;
        clear_logs();
        for (int i = 0; i < 200; i++) begin
            draw_word(r);
            s = (r[1:0] == 2'b00);
            f = (r[4:2] == 3'b000);
            step(s, f);
            if (s || f) begin
                hazards++;
            end
        end
        repeat (RANDOM_CYCLES - 200) step(1'b0, 1'b0);
        settle();
        require(hazard_q.size() == hazards, "hazard event count differs from driven cycles");
        check_val("retire_count", retire_count, m_retire_cnt);
        check_val("stall_count", stall_count, m_stall_cnt);
        check_val("flush_count", flush_count, m_flush_cnt);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b0;
        stall = 1'b0;
        flush = 1'b0;
        probe = '0;
        rng = 32'd38659;
        check_on = 1'b0;
        cycle_count = 0;
        fail_count = 0;

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;
        settle();

        free_run();
        stall_sequence();
        flush_sequence();
        stall_with_flush();
        random_mix();

        if (fail_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
src/trace_pkg.sv
src/stage_tracker.sv
src/trace_buffer.sv
src/hazard_log.sv
src/retire_reporter.sv
src/pipe_trace_top.sv
dv/pipe_trace_tb.sv

// File: src/hazard_log.sv
////////////////////////////////////////////////////////////////////////////
// Hazard event strobe and saturating stall and flush cycle counters
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module hazard_log (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  logic [trace_pkg::CYC_W-1:0]   cycle,
    output logic                          hazard_valid,
    output trace_pkg::hazard_event_t      hazard,
    output logic [trace_pkg::CNT_W-1:0]   stall_count,
    output logic [trace_pkg::CNT_W-1:0]   flush_count
);

    always_ff @(posedge clk) begin
        if (!rst) begin
            hazard_valid <= 1'b0;
            stall_count  <= '0;
            flush_count  <= '0;
        end else begin
            hazard_valid <= stall | flush;
            // Both count when both are high, each stops at all ones
            if (stall && stall_count != '1) begin
                stall_count <= stall_count + 1'b1;
            end
            if (flush && flush_count != '1) begin
                flush_count <= flush_count + 1'b1;
            end
        end
    end

    // Event payload, stall takes the cause when both are high
    always_ff @(posedge clk) begin
        if (stall || flush) begin
            hazard.cause <= stall ? trace_pkg::CAUSE_STALL : trace_pkg::CAUSE_FLUSH;
            hazard.cycle <= cycle;
        end
    end

    a_stall_no_wrap: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) |-> stall_count >= $past(stall_count));

    a_flush_no_wrap: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) |-> flush_count >= $past(flush_count));

endmodule

`default_nettype wire

// File: src/pipe_trace_top.sv
////////////////////////////////////////////////////////////////////////////
// Pipeline trace unit top, wires the tracker, record buffer,
// hazard log and retire reporter to the CPU probe and stall/flush lines
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module pipe_trace_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          stall,
    input  logic                          flush,
    input  trace_pkg::stage_probe_t       probe,
    output logic                          retire_valid,
    output trace_pkg::retire_record_t     retire,
    output logic [trace_pkg::CNT_W-1:0]   retire_count,
    output logic                          hazard_valid,
    output trace_pkg::hazard_event_t      hazard,
    output logic [trace_pkg::CNT_W-1:0]   stall_count,
    output logic [trace_pkg::CNT_W-1:0]   flush_count
);

    trace_pkg::stage_tags_t   tags;
    trace_pkg::trace_record_t wb_record;

    stage_tracker u_tracker (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .tags  (tags)
    );

    trace_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .tags      (tags),
        .probe     (probe),
        .wb_record (wb_record)
    );

    // Events are stamped with the same cycle count as the records
    hazard_log u_hazard (
        .clk          (clk),
        .rst          (rst),
        .stall        (stall),
        .flush        (flush),
        .cycle        (tags.cycle),
        .hazard_valid (hazard_valid),
        .hazard       (hazard),
        .stall_count  (stall_count),
        .flush_count  (flush_count)
    );

    retire_reporter u_reporter (
        .clk          (clk),
        .rst          (rst),
        .tags         (tags),
        .wb_record    (wb_record),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_count (retire_count)
    );

endmodule

`default_nettype wire

// File: src/retire_reporter.sv
////////////////////////////////////////////////////////////////////////////
// Registers the finished wb record as a one-cycle retire strobe,
// adds the fetch to retire latency and keeps the retire count
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module retire_reporter (
    input  logic                          clk,
    input  logic                          rst,
    input  trace_pkg::stage_tags_t        tags,
    input  trace_pkg::trace_record_t      wb_record,
    output logic                          retire_valid,
    output trace_pkg::retire_record_t     retire,
    output logic [trace_pkg::CNT_W-1:0]   retire_count
);

    // Last id sent out, for the ordering check
    logic                       have_prev;
    logic [trace_pkg::ID_W-1:0] prev_id;
    logic [trace_pkg::ID_W-1:0] id_step;

    always_ff @(posedge clk) begin
        if (!rst) begin
            retire_valid <= 1'b0;
            retire_count <= '0;
            have_prev    <= 1'b0;
        end else begin
            retire_valid <= tags.wb.valid;
            if (tags.wb.valid) begin
                retire_count <= retire_count + 1'b1;
            end
            if (retire_valid) begin
                have_prev <= 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Record and latency
    ////////////////////////////////////////////////////////////////////////////

    // Stamps wrap modulo 2**CYC_W, plain subtraction stays correct
    always_ff @(posedge clk) begin
        if (tags.wb.valid) begin
            retire.rec     <= wb_record;
            retire.latency <= wb_record.wb_cyc - wb_record.fetch_cyc
                              + trace_pkg::CYC_W'(trace_pkg::RETIRE_LAG);
        end
        if (retire_valid) begin
            prev_id <= retire.rec.id;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // Ids wrap too, so "greater" means a forward step of less than half range
    assign id_step = retire.rec.id - prev_id;

    a_retire_in_order: assert property (@(posedge clk) disable iff (!rst)
        retire_valid && have_prev |-> id_step != '0 && !id_step[trace_pkg::ID_W-1]);

endmodule

`default_nettype wire

// File: src/stage_tracker.sv
////////////////////////////////////////////////////////////////////////////
// Moves sequence ids down the five stages under stall and flush
// and keeps the free running cycle count used for every stamp
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    output trace_pkg::stage_tags_t tags
);

    trace_pkg::stage_tag_t fetch_q;
    trace_pkg::stage_tag_t decode_q;
    trace_pkg::stage_tag_t execute_q;
    trace_pkg::stage_tag_t memory_q;
    trace_pkg::stage_tag_t wb_q;

    logic [trace_pkg::CYC_W-1:0] cycle_q;

    // Flattened view for the uniqueness check
    logic [trace_pkg::NUM_STAGES-1:0] stage_valid;
    logic [trace_pkg::ID_W-1:0]       stage_id [trace_pkg::NUM_STAGES];
    logic                             id_clash;

    ////////////////////////////////////////////////////////////////////////////
    // Stage movement
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst) begin
            fetch_q   <= '{valid: 1'b1, id: '0};
            decode_q  <= '{valid: 1'b0, id: '0};
            execute_q <= '{valid: 1'b0, id: '0};
            memory_q  <= '{valid: 1'b0, id: '0};
            wb_q      <= '{valid: 1'b0, id: '0};
            cycle_q   <= '0;
        end else begin
            cycle_q <= cycle_q + 1'b1;

            // Back end always drains
            memory_q <= execute_q;
            wb_q     <= memory_q;

            if (stall) begin
                // Fetch and decode hold, bubble into execute
                execute_q.valid <= 1'b0;
            end else if (flush) begin
                fetch_q.id <= fetch_q.id + 1'b1;
                // The instruction just fetched is discarded
                decode_q  <= '{valid: 1'b0, id: fetch_q.id};
                execute_q <= decode_q;
            end else begin
                fetch_q.id <= fetch_q.id + 1'b1;
                decode_q   <= fetch_q;
                execute_q  <= decode_q;
            end
        end
    end

    always_comb begin
        tags.fetch   = fetch_q;
        tags.decode  = decode_q;
        tags.execute = execute_q;
        tags.memory  = memory_q;
        tags.wb      = wb_q;
        tags.cycle   = cycle_q;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    assign stage_valid = {wb_q.valid, memory_q.valid, execute_q.valid,
                          decode_q.valid, fetch_q.valid};
    assign stage_id = '{fetch_q.id, decode_q.id, execute_q.id, memory_q.id, wb_q.id};

    always_comb begin
        id_clash = 1'b0;
        for (int i = 0; i < trace_pkg::NUM_STAGES; i++) begin
            for (int j = i + 1; j < trace_pkg::NUM_STAGES; j++) begin
                if (stage_valid[i] && stage_valid[j] && stage_id[i] == stage_id[j]) begin
                    id_clash = 1'b1;
                end
            end
        end
    end

    // One instruction can sit in only one stage
    a_unique_ids: assert property (@(posedge clk) disable iff (!rst) !id_clash);

    // A stall in the previous cycle kept decode on the same instruction
    a_stall_holds_decode: assert property (@(posedge clk) disable iff (!rst)
        $past(rst) && $past(stall) |-> decode_q.id == $past(decode_q.id));

endmodule

`default_nettype wire

// File: src/trace_buffer.sv
////////////////////////////////////////////////////////////////////////////
// Per id record store, stamps cycle and probe value in every valid stage
// The wb slot is presented combinationally with this cycle's wb fields
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module trace_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  trace_pkg::stage_tags_t   tags,
    input  trace_pkg::stage_probe_t  probe,
    output trace_pkg::trace_record_t wb_record
);

    trace_pkg::trace_record_t mem [trace_pkg::TRACE_DEPTH];

    logic [trace_pkg::SLOT_W-1:0] fetch_slot;
    logic [trace_pkg::SLOT_W-1:0] decode_slot;
    logic [trace_pkg::SLOT_W-1:0] execute_slot;
    logic [trace_pkg::SLOT_W-1:0] memory_slot;
    logic [trace_pkg::SLOT_W-1:0] wb_slot;

    logic [trace_pkg::NUM_STAGES-1:0] stage_valid;
    logic [trace_pkg::SLOT_W-1:0]     stage_slot [trace_pkg::NUM_STAGES];
    logic                             slot_clash;

    assign fetch_slot   = tags.fetch.id[trace_pkg::SLOT_W-1:0];
    assign decode_slot  = tags.decode.id[trace_pkg::SLOT_W-1:0];
    assign execute_slot = tags.execute.id[trace_pkg::SLOT_W-1:0];
    assign memory_slot  = tags.memory.id[trace_pkg::SLOT_W-1:0];
    assign wb_slot      = tags.wb.id[trace_pkg::SLOT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Stamping
    ////////////////////////////////////////////////////////////////////////////

    // Held stages are stamped again, so each stamp is the last cycle there
    always_ff @(posedge clk) begin
        if (rst) begin
            if (tags.fetch.valid) begin
                mem[fetch_slot].id        <= tags.fetch.id;
                mem[fetch_slot].pc        <= probe.fetch_pc;
                mem[fetch_slot].instr     <= probe.fetch_instr;
                mem[fetch_slot].fetch_cyc <= tags.cycle;
            end
            if (tags.decode.valid) begin
                mem[decode_slot].decode_cyc <= tags.cycle;
            end
            if (tags.execute.valid) begin
                mem[execute_slot].execute_cyc <= tags.cycle;
                mem[execute_slot].ex_result   <= probe.ex_result;
            end
            if (tags.memory.valid) begin
                mem[memory_slot].memory_cyc <= tags.cycle;
                mem[memory_slot].mem_addr   <= probe.mem_addr;
            end
            if (tags.wb.valid) begin
                mem[wb_slot].wb_cyc  <= tags.cycle;
                mem[wb_slot].wb_data <= probe.wb_data;
            end
        end
    end

    // wb fields are written at this same edge, so bypass them
    always_comb begin
        wb_record         = mem[wb_slot];
        wb_record.wb_cyc  = tags.cycle;
        wb_record.wb_data = probe.wb_data;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    assign stage_valid = {tags.wb.valid, tags.memory.valid, tags.execute.valid,
                          tags.decode.valid, tags.fetch.valid};
    assign stage_slot = '{fetch_slot, decode_slot, execute_slot, memory_slot, wb_slot};

    always_comb begin
        slot_clash = 1'b0;
        for (int i = 0; i < trace_pkg::NUM_STAGES; i++) begin
            for (int j = i + 1; j < trace_pkg::NUM_STAGES; j++) begin
                if (stage_valid[i] && stage_valid[j] && stage_slot[i] == stage_slot[j]) begin
                    slot_clash = 1'b1;
                end
            end
        end
    end

    // Depth too small for the ids in flight would overwrite a live record
    a_no_slot_alias: assert property (@(posedge clk) disable iff (!rst) !slot_clash);

endmodule

`default_nettype wire

// File: src/trace_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared sizes and types of the pipeline trace unit
// Every trace module refers to these by trace_pkg:: scoped names
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package trace_pkg;

    // Record slots, the slot is the id modulo the depth
    localparam int unsigned TRACE_DEPTH = 8;
    localparam int unsigned SLOT_W      = $clog2(TRACE_DEPTH);
    localparam int unsigned NUM_STAGES  = 5;

    localparam int unsigned ID_W  = 8;
    localparam int unsigned CYC_W = 16;
    localparam int unsigned CNT_W = 16;

    // Retire strobe comes one cycle after the wb cycle
    localparam int unsigned RETIRE_LAG = 1;

    ////////////////////////////////////////////////////////////////////////////
    // CPU side
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [31:0] fetch_pc;
        logic [31:0] fetch_instr;
        logic [31:0] ex_result;
        logic [31:0] mem_addr;
        logic [31:0] wb_data;
    } stage_probe_t;

    typedef struct packed {
        logic            valid;
        logic [ID_W-1:0] id;
    } stage_tag_t;

    typedef struct packed {
        stage_tag_t       fetch;
        stage_tag_t       decode;
        stage_tag_t       execute;
        stage_tag_t       memory;
        stage_tag_t       wb;
        logic [CYC_W-1:0] cycle;
    } stage_tags_t;

    ////////////////////////////////////////////////////////////////////////////
    // Records and events
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [ID_W-1:0]  id;
        logic [31:0]      pc;
        logic [31:0]      instr;
        logic [CYC_W-1:0] fetch_cyc;
        logic [CYC_W-1:0] decode_cyc;
        logic [CYC_W-1:0] execute_cyc;
        logic [CYC_W-1:0] memory_cyc;
        logic [CYC_W-1:0] wb_cyc;
        logic [31:0]      ex_result;
        logic [31:0]      mem_addr;
        logic [31:0]      wb_data;
    } trace_record_t;

    typedef struct packed {
        trace_record_t    rec;
        logic [CYC_W-1:0] latency;
    } retire_record_t;

    typedef enum logic {
        CAUSE_STALL = 1'b0,
        CAUSE_FLUSH = 1'b1
    } hazard_cause_t;

    typedef struct packed {
        hazard_cause_t    cause;
        logic [CYC_W-1:0] cycle;
    } hazard_event_t;

endpackage

`default_nettype wire
